/* Bender.yml */
package:
  name: backend_core

export_include_dirs:
  - common

sources:
  - common/backend_pkg.sv
  - common/stage_if.sv
  - hdl/regfile_scoreboard.sv
  - decode/decode_stage.sv
  - execute/execute_stage.sv
  - hdl/mem_stage.sv
  - hdl/commit_stage.sv
  - hdl/backend_core.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_backend_core.sv

/* backend_core.f */
+incdir+common
+incdir+tb
common/backend_pkg.sv
common/stage_if.sv
hdl/regfile_scoreboard.sv
decode/decode_stage.sv
execute/execute_stage.sv
hdl/mem_stage.sv
hdl/commit_stage.sv
hdl/backend_core.sv
tb/tb_backend_core.sv

/* common/backend_pkg.sv */
// Types shared by all pipeline stages and only the supported RV32I subset has an opcode
`default_nettype none

`include "backend_settings.svh"

package backend_pkg;

  // Internal opcodes after decode, anything unsupported becomes OP_NOP
  typedef enum logic [3:0] {
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_ADDI,
    OP_LUI,
    OP_LW,
    OP_SW,
    OP_BEQ,
    OP_BNE,
    OP_NOP
  } opcode_e;

  // Load/store sequencing in the memory stage
  typedef enum logic [1:0] {
    MEM_IDLE,
    MEM_REQ,
    MEM_WAIT
  } mem_state_e;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Micro-op carried from decode to commit
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // The pc is a byte address and the frontend starts fetching at `BACKEND_RESET_PC
  typedef struct packed {
    opcode_e                    opcode;
    logic [`BACKEND_AREG_W-1:0] rd;
    logic                       rd_we;   // Never set for x0
    logic [`BACKEND_XLEN-1:0]   pc;
    logic [`BACKEND_XLEN-1:0]   op_a;    // Value of rs1
    logic [`BACKEND_XLEN-1:0]   op_b;    // Value of rs2, also the store data
    logic [`BACKEND_XLEN-1:0]   imm;
    logic [`BACKEND_XLEN-1:0]   result;  // ALU value, then load data
  } uop_t;

endpackage

`default_nettype wire

/* common/backend_settings.svh */
// RV32I widths are fixed here and the reset PC is read only by the testbench frontend
`ifndef BACKEND_SETTINGS_SVH
`define BACKEND_SETTINGS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Architectural sizes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// Data and address width
`define BACKEND_XLEN 32

// Integer register count and its address width
`define BACKEND_NREG 32
`define BACKEND_AREG_W 5

// First fetch address after reset
`define BACKEND_RESET_PC 32'h0000_0000

`endif

/* common/stage_if.sv */
// Valid/ready link between stages and the producer holds uop while valid waits for ready
`timescale 1ns/1ps
`default_nettype none

interface stage_if import backend_pkg::*; ();

  logic valid;
  logic ready;
  uop_t uop;

  modport producer (
    output valid,
    output uop,
    input  ready
  );

  modport consumer (
    input  valid,
    input  uop,
    output ready
  );

endinterface

`default_nettype wire

/* decode/decode_stage.sv */
// One instruction deep, no forwarding, and issue waits until rs1, rs2 and rd are all clear
`timescale 1ns/1ps
`default_nettype none

`include "backend_settings.svh"

module decode_stage import backend_pkg::*; (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       ibuf_valid_i,
  output logic                       ibuf_ready_o,
  input  logic [31:0]                ibuf_instr_i,
  input  logic [`BACKEND_XLEN-1:0]   ibuf_pc_i,
  input  logic                       flush_i,
  output logic [`BACKEND_AREG_W-1:0] rs1_addr_o,
  output logic [`BACKEND_AREG_W-1:0] rs2_addr_o,
  output logic [`BACKEND_AREG_W-1:0] rd_addr_o,
  input  logic [`BACKEND_XLEN-1:0]   rs1_data_i,
  input  logic [`BACKEND_XLEN-1:0]   rs2_data_i,
  input  logic                       rs1_pending_i,
  input  logic                       rs2_pending_i,
  input  logic                       rd_pending_i,
  output logic                       set_pending_o,
  output logic [`BACKEND_AREG_W-1:0] set_addr_o,
  stage_if.producer                  out
);

  logic                     ib_valid_q;
  logic [31:0]              ib_instr_q;
  logic [`BACKEND_XLEN-1:0] ib_pc_q;
  opcode_e                  opcode;
  logic [`BACKEND_XLEN-1:0] imm;
  logic                     use_rs1;
  logic                     use_rs2;
  logic                     rd_we;
  logic                     hazard;
  logic                     issue;
  logic                     ibuf_fire;

  assign rs1_addr_o = ib_instr_q[19:15];
  assign rs2_addr_o = ib_instr_q[24:20];
  assign rd_addr_o  = ib_instr_q[11:7];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Decoder
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin : decoder
    opcode = OP_NOP;
    imm    = {{20{ib_instr_q[31]}}, ib_instr_q[31:20]};  // I-type unless overridden
    case (ib_instr_q[6:0])
      7'b0110011: begin
        case ({ib_instr_q[31:25], ib_instr_q[14:12]})
          10'b0000000_000: opcode = OP_ADD;
          10'b0100000_000: opcode = OP_SUB;
          10'b0000000_100: opcode = OP_XOR;
          10'b0000000_110: opcode = OP_OR;
          10'b0000000_111: opcode = OP_AND;
          default:         opcode = OP_NOP;
        endcase
      end
      7'b0010011: if (ib_instr_q[14:12] == 3'b000) opcode = OP_ADDI;
      7'b0000011: if (ib_instr_q[14:12] == 3'b010) opcode = OP_LW;
      7'b0110111: begin
        opcode = OP_LUI;
        imm    = {ib_instr_q[31:12], 12'b0};
      end
      7'b0100011: begin
        if (ib_instr_q[14:12] == 3'b010) opcode = OP_SW;
        imm = {{20{ib_instr_q[31]}}, ib_instr_q[31:25], ib_instr_q[11:7]};
      end
      7'b1100011: begin
        if (ib_instr_q[14:12] == 3'b000) opcode = OP_BEQ;
        if (ib_instr_q[14:12] == 3'b001) opcode = OP_BNE;
        imm = {{19{ib_instr_q[31]}}, ib_instr_q[31], ib_instr_q[7],
               ib_instr_q[30:25], ib_instr_q[11:8], 1'b0};
      end
      default: opcode = OP_NOP;
    endcase
  end

  assign use_rs1 = !(opcode inside {OP_LUI, OP_NOP});
  assign use_rs2 = opcode inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SW, OP_BEQ, OP_BNE};
  assign rd_we   = (opcode inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI, OP_LUI, OP_LW})
                   && (rd_addr_o != '0);

  // Rd is checked too so an older write cannot land after a younger one
  assign hazard = (use_rs1 && rs1_pending_i) || (use_rs2 && rs2_pending_i) ||
                  (rd_we && rd_pending_i);

  assign out.valid = ib_valid_q && !hazard && !flush_i;  // Held instruction is younger than the branch
  assign out.uop   = '{opcode: opcode, rd: rd_addr_o, rd_we: rd_we, pc: ib_pc_q,
                       op_a: use_rs1 ? rs1_data_i : '0,  // Operands the opcode ignores read as zero
                       op_b: use_rs2 ? rs2_data_i : '0,
                       imm: imm, result: '0};

  assign issue         = out.valid && out.ready;
  assign ibuf_ready_o  = !flush_i && (!ib_valid_q || issue);
  assign ibuf_fire     = ibuf_valid_i && ibuf_ready_o;
  assign set_pending_o = issue && rd_we;
  assign set_addr_o    = rd_addr_o;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ib_valid_q <= 1'b0;
    end else if (flush_i) begin
      ib_valid_q <= 1'b0;
    end else if (ibuf_fire) begin
      ib_valid_q <= 1'b1;
    end else if (issue) begin
      ib_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ibuf_fire) begin
      ib_instr_q <= ibuf_instr_i;
      ib_pc_q    <= ibuf_pc_i;
    end
  end

  // A stalled uop stays put unless a flush removes it
  a_uop_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out.valid && !out.ready |=> flush_i || (out.valid && $stable(out.uop)));

endmodule

`default_nettype wire

/* execute/execute_stage.sv */
// Branches resolve here and a taken one flushes only the single instruction held in decode
`timescale 1ns/1ps
`default_nettype none

`include "backend_settings.svh"

module execute_stage import backend_pkg::*; (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  stage_if.consumer                in,
  stage_if.producer                out,
  output logic                     flush_o,
  output logic [`BACKEND_XLEN-1:0] flush_pc_o
);

  logic                     valid_q;
  uop_t                     uop_q;
  uop_t                     res_uop;
  logic [`BACKEND_XLEN-1:0] result;
  logic                     taken;

  assign in.ready = !valid_q || out.ready;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (in.valid && in.ready) begin
      valid_q <= 1'b1;
    end else if (out.ready) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (in.valid && in.ready) begin
      uop_q <= in.uop;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // ALU and branch compare
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin : alu
    case (uop_q.opcode)
      OP_ADD:                result = uop_q.op_a + uop_q.op_b;
      OP_SUB:                result = uop_q.op_a - uop_q.op_b;
      OP_AND:                result = uop_q.op_a & uop_q.op_b;
      OP_OR:                 result = uop_q.op_a | uop_q.op_b;
      OP_XOR:                result = uop_q.op_a ^ uop_q.op_b;
      OP_ADDI, OP_LW, OP_SW: result = uop_q.op_a + uop_q.imm;  // Loads and stores get the address
      OP_LUI:                result = uop_q.imm;
      default:               result = '0;
    endcase
  end

  assign taken = ((uop_q.opcode == OP_BEQ) && (uop_q.op_a == uop_q.op_b)) ||
                 ((uop_q.opcode == OP_BNE) && (uop_q.op_a != uop_q.op_b));

  always_comb begin
    res_uop        = uop_q;
    res_uop.result = result;
  end

  assign out.valid = valid_q;
  assign out.uop   = res_uop;

  // Raised only in the cycle the branch moves on, so a stalled branch flushes once
  assign flush_o    = valid_q && out.ready && taken;
  assign flush_pc_o = uop_q.pc + uop_q.imm;

endmodule

`default_nettype wire

/* hdl/backend_core.sv */
// Single-issue in-order RV32I subset and the frontend must drop an instruction offered during flush
`timescale 1ns/1ps
`default_nettype none

`include "backend_settings.svh"

module backend_core (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       ibuf_valid_i,
  output logic                       ibuf_ready_o,
  input  logic [31:0]                ibuf_instr_i,
  input  logic [`BACKEND_XLEN-1:0]   ibuf_pc_i,
  output logic                       dmem_req_valid_o,
  input  logic                       dmem_req_ready_i,
  output logic                       dmem_req_we_o,
  output logic [`BACKEND_XLEN-1:0]   dmem_req_addr_o,
  output logic [`BACKEND_XLEN-1:0]   dmem_req_wdata_o,
  input  logic                       dmem_rsp_valid_i,
  input  logic [`BACKEND_XLEN-1:0]   dmem_rsp_rdata_i,
  output logic                       commit_valid_o,
  output logic                       commit_we_o,
  output logic [`BACKEND_AREG_W-1:0] commit_areg_o,
  output logic [`BACKEND_XLEN-1:0]   commit_wdata_o,
  output logic                       flush_o,
  output logic [`BACKEND_XLEN-1:0]   flush_pc_o
);

  logic [`BACKEND_AREG_W-1:0] rs1_addr;
  logic [`BACKEND_AREG_W-1:0] rs2_addr;
  logic [`BACKEND_AREG_W-1:0] rd_addr;
  logic [`BACKEND_XLEN-1:0]   rs1_data;
  logic [`BACKEND_XLEN-1:0]   rs2_data;
  logic                       rs1_pending;
  logic                       rs2_pending;
  logic                       rd_pending;
  logic                       set_pending;
  logic [`BACKEND_AREG_W-1:0] set_addr;
  logic                       wr_en;
  logic [`BACKEND_AREG_W-1:0] wr_addr;
  logic [`BACKEND_XLEN-1:0]   wr_data;

  stage_if dec_ex_if ();
  stage_if ex_mem_if ();
  stage_if mem_cm_if ();

  regfile_scoreboard regfile_scoreboard_i (
    .clk_i, .rst_n_i,
    .rs1_addr_i(rs1_addr), .rs2_addr_i(rs2_addr), .rd_addr_i(rd_addr),
    .rs1_data_o(rs1_data), .rs2_data_o(rs2_data),
    .rs1_pending_o(rs1_pending), .rs2_pending_o(rs2_pending), .rd_pending_o(rd_pending),
    .set_pending_i(set_pending), .set_addr_i(set_addr),
    .wr_en_i(wr_en), .wr_addr_i(wr_addr), .wr_data_i(wr_data)
  );

  decode_stage decode_stage_i (
    .clk_i, .rst_n_i,
    .ibuf_valid_i, .ibuf_ready_o, .ibuf_instr_i, .ibuf_pc_i,
    .flush_i(flush_o),
    .rs1_addr_o(rs1_addr), .rs2_addr_o(rs2_addr), .rd_addr_o(rd_addr),
    .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
    .rs1_pending_i(rs1_pending), .rs2_pending_i(rs2_pending), .rd_pending_i(rd_pending),
    .set_pending_o(set_pending), .set_addr_o(set_addr),
    .out(dec_ex_if)
  );

  execute_stage execute_stage_i (
    .clk_i, .rst_n_i,
    .in(dec_ex_if), .out(ex_mem_if),
    .flush_o, .flush_pc_o
  );

  mem_stage mem_stage_i (
    .clk_i, .rst_n_i,
    .in(ex_mem_if), .out(mem_cm_if),
    .dmem_req_valid_o, .dmem_req_ready_i, .dmem_req_we_o,
    .dmem_req_addr_o, .dmem_req_wdata_o,
    .dmem_rsp_valid_i, .dmem_rsp_rdata_i
  );

  commit_stage commit_stage_i (
    .clk_i, .rst_n_i,
    .in(mem_cm_if),
    .wr_en_o(wr_en), .wr_addr_o(wr_addr), .wr_data_o(wr_data),
    .commit_valid_o, .commit_we_o, .commit_areg_o, .commit_wdata_o
  );

endmodule

`default_nettype wire

/* hdl/commit_stage.sv */
// Always ready and retires at most one uop per cycle in program order
`timescale 1ns/1ps
`default_nettype none

`include "backend_settings.svh"

module commit_stage import backend_pkg::*; (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  stage_if.consumer                  in,
  output logic                       wr_en_o,
  output logic [`BACKEND_AREG_W-1:0] wr_addr_o,
  output logic [`BACKEND_XLEN-1:0]   wr_data_o,
  output logic                       commit_valid_o,
  output logic                       commit_we_o,
  output logic [`BACKEND_AREG_W-1:0] commit_areg_o,
  output logic [`BACKEND_XLEN-1:0]   commit_wdata_o
);

  logic valid_q;
  uop_t uop_q;

  assign in.ready = 1'b1;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= in.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (in.valid) begin
      uop_q <= in.uop;
    end
  end

  assign commit_valid_o = valid_q;
  assign commit_we_o    = valid_q && uop_q.rd_we;  // Stores, branches and no-ops write nothing
  assign commit_areg_o  = uop_q.rd;
  assign commit_wdata_o = uop_q.result;

  assign wr_en_o   = commit_we_o;  // Also clears the pending bit
  assign wr_addr_o = uop_q.rd;
  assign wr_data_o = uop_q.result;

endmodule

`default_nettype wire

/* hdl/mem_stage.sv */
// Word-aligned LW and SW only, with one outstanding request and one response per request
`timescale 1ns/1ps
`default_nettype none

`include "backend_settings.svh"

module mem_stage import backend_pkg::*; (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  stage_if.consumer                in,
  stage_if.producer                out,
  output logic                     dmem_req_valid_o,
  input  logic                     dmem_req_ready_i,
  output logic                     dmem_req_we_o,
  output logic [`BACKEND_XLEN-1:0] dmem_req_addr_o,
  output logic [`BACKEND_XLEN-1:0] dmem_req_wdata_o,
  input  logic                     dmem_rsp_valid_i,
  input  logic [`BACKEND_XLEN-1:0] dmem_rsp_rdata_i
);

  mem_state_e state_q;
  logic       valid_q;
  uop_t       uop_q;
  logic       is_mem;

  assign is_mem    = in.uop.opcode inside {OP_LW, OP_SW};
  assign in.ready  = !valid_q || ((state_q == MEM_IDLE) && out.ready);
  assign out.valid = valid_q && (state_q == MEM_IDLE);  // Memory ops return here after the response
  assign out.uop   = uop_q;

  assign dmem_req_valid_o = (state_q == MEM_REQ);
  assign dmem_req_we_o    = (uop_q.opcode == OP_SW);
  assign dmem_req_addr_o  = uop_q.result;
  assign dmem_req_wdata_o = uop_q.op_b;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= MEM_IDLE;
      valid_q <= 1'b0;
    end else begin
      case (state_q)
        MEM_IDLE: begin
          if (in.valid && in.ready) begin
            valid_q <= 1'b1;
            if (is_mem) state_q <= MEM_REQ;
          end else if (out.ready) begin
            valid_q <= 1'b0;
          end
        end
        MEM_REQ:  if (dmem_req_ready_i) state_q <= MEM_WAIT;
        MEM_WAIT: if (dmem_rsp_valid_i) state_q <= MEM_IDLE;
        default:  state_q <= MEM_IDLE;
      endcase
    end
  end

  // Store responses carry no data, so result keeps the address
  always_ff @(posedge clk_i) begin
    if (in.valid && in.ready) begin
      uop_q <= in.uop;
    end else if ((state_q == MEM_WAIT) && dmem_rsp_valid_i && (uop_q.opcode == OP_LW)) begin
      uop_q.result <= dmem_rsp_rdata_i;
    end
  end

  a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    dmem_req_valid_o && !dmem_req_ready_i |=> dmem_req_valid_o &&
    $stable(dmem_req_we_o) && $stable(dmem_req_addr_o) && $stable(dmem_req_wdata_o));

endmodule

`default_nettype wire

/* hdl/regfile_scoreboard.sv */
// Two read ports and one write port, x0 reads zero and is never marked pending
`timescale 1ns/1ps
`default_nettype none

`include "backend_settings.svh"

module regfile_scoreboard (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic [`BACKEND_AREG_W-1:0] rs1_addr_i,
  input  logic [`BACKEND_AREG_W-1:0] rs2_addr_i,
  input  logic [`BACKEND_AREG_W-1:0] rd_addr_i,
  output logic [`BACKEND_XLEN-1:0]   rs1_data_o,
  output logic [`BACKEND_XLEN-1:0]   rs2_data_o,
  output logic                       rs1_pending_o,
  output logic                       rs2_pending_o,
  output logic                       rd_pending_o,
  input  logic                       set_pending_i,
  input  logic [`BACKEND_AREG_W-1:0] set_addr_i,
  input  logic                       wr_en_i,
  input  logic [`BACKEND_AREG_W-1:0] wr_addr_i,
  input  logic [`BACKEND_XLEN-1:0]   wr_data_i
);

  logic [`BACKEND_XLEN-1:0] regs_q [1:`BACKEND_NREG-1];
  logic [`BACKEND_NREG-1:0] pending_q;

  always_ff @(posedge clk_i) begin
    if (wr_en_i && (wr_addr_i != '0)) begin
      regs_q[wr_addr_i] <= wr_data_i;
    end
  end

  // Set wins over clear, though decode never sets a register that is still pending
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pending_q <= '0;
    end else begin
      if (wr_en_i) pending_q[wr_addr_i] <= 1'b0;
      if (set_pending_i && (set_addr_i != '0)) pending_q[set_addr_i] <= 1'b1;
    end
  end

  assign rs1_data_o    = (rs1_addr_i == '0) ? '0 : regs_q[rs1_addr_i];
  assign rs2_data_o    = (rs2_addr_i == '0) ? '0 : regs_q[rs2_addr_i];
  assign rs1_pending_o = pending_q[rs1_addr_i];
  assign rs2_pending_o = pending_q[rs2_addr_i];
  assign rd_pending_o  = pending_q[rd_addr_i];

  // Commit only retires writes that decode announced at issue
  a_write_was_pending: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wr_en_i |-> pending_q[wr_addr_i]);

endmodule

`default_nettype wire

/* tb/backend_tests.svh */
// Included inside the testbench module, branch targets must stay inside the loaded program
`ifndef BACKEND_TESTS_SVH
`define BACKEND_TESTS_SVH

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                     input int rd, input int rs1, input int rs2);
  return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'b0110011};
endfunction

function automatic logic [31:0] enc_addi(input int rd, input int rs1, input int imm);
  return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b0010011};
endfunction

function automatic logic [31:0] enc_lui(input int rd, input int imm20);
  return {imm20[19:0], rd[4:0], 7'b0110111};
endfunction

function automatic logic [31:0] enc_lw(input int rd, input int rs1, input int imm);
  return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], 7'b0000011};
endfunction

function automatic logic [31:0] enc_sw(input int rs2, input int rs1, input int imm);
  return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
endfunction

function automatic logic [31:0] enc_branch(input logic [2:0] f3, input int rs1, input int rs2,
                                          input int imm);
  return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], 7'b1100011};
endfunction

task automatic emit(input logic [31:0] instr);
  prog[prog_len] = instr;
  prog_len++;
endtask

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ISA reference model over the loaded program
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
task automatic run_golden();
  logic [31:0] pc;
  logic [31:0] ins;
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] res;
  logic [31:0] next;
  logic        we;
  int          steps;
  pc = `BACKEND_RESET_PC;
  steps = 0;
  while (((pc >> 2) < prog_len) && (steps < 256)) begin
    ins  = prog[pc[7:2]];
    a    = gregs[ins[19:15]];
    b    = gregs[ins[24:20]];
    we   = 1'b0;
    res  = '0;
    next = pc + 32'd4;
    case (ins[6:0])
      7'b0110011: begin
        we = 1'b1;
        case ({ins[31:25], ins[14:12]})
          10'b0000000_000: res = a + b;
          10'b0100000_000: res = a - b;
          10'b0000000_100: res = a ^ b;
          10'b0000000_110: res = a | b;
          10'b0000000_111: res = a & b;
          default:         we = 1'b0;
        endcase
      end
      7'b0010011: begin
        we  = (ins[14:12] == 3'b000);
        res = a + {{20{ins[31]}}, ins[31:20]};
      end
      7'b0110111: begin
        we  = 1'b1;
        res = {ins[31:12], 12'h0};
      end
      7'b0000011: begin
        we  = (ins[14:12] == 3'b010);
        res = gmem[(a + {{20{ins[31]}}, ins[31:20]}) >> 2 & 32'hFF];
      end
      7'b0100011: begin
        if (ins[14:12] == 3'b010) gmem[(a + {{20{ins[31]}}, ins[31:25], ins[11:7]}) >> 2 & 32'hFF] = b;
      end
      7'b1100011: begin
        if (((ins[14:12] == 3'b000) && (a == b)) || ((ins[14:12] == 3'b001) && (a != b))) begin
          next = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
          exp_flush.push_back(next);
        end
      end
      default: we = 1'b0;
    endcase
    we = we && (ins[11:7] != 5'd0);
    exp_we.push_back(we);
    exp_areg.push_back(ins[11:7]);
    exp_data.push_back(res);
    if (we) gregs[ins[11:7]] = res;
    pc = next;
    steps++;
  end
endtask

task automatic run_program(input string name, input int errs_before);
  run_golden();
  instr_total += prog_len;
  @(posedge clk_i);
  fe_pc  = `BACKEND_RESET_PC;
  fe_run = 1'b1;
  while (exp_we.size() != 0) @(posedge clk_i);
  repeat (6) @(negedge clk_i);  // Let a stray commit or flush show up
  fe_run = 1'b0;
  if (exp_flush.size() != 0) begin
    $display("Test %s saw %0d fewer flushes than expected", name, exp_flush.size());
    err_count++;
    exp_flush.delete();
  end
  test_count++;
  $display("Test %s finished with %0d errors", name, err_count - errs_before);
endtask

task automatic test_alu_ops();
  int errs_before;
  errs_before = err_count;
  check_value("ibuf_ready_o", 1, ibuf_ready_o);
  check_value("commit_valid_o", 0, commit_valid_o);
  check_value("flush_o", 0, flush_o);
  check_value("dmem_req_valid_o", 0, dmem_req_valid_o);
  prog_len = 0;
  emit(enc_addi(1, 0, 'h123));
  emit(enc_lui(2, 'hABCDE));
  emit(enc_addi(3, 0, -5));
  emit(enc_r(7'h00, 3'b000, 4, 1, 3));
  emit(enc_r(7'h20, 3'b000, 5, 1, 3));
  emit(enc_r(7'h00, 3'b111, 6, 2, 3));
  emit(enc_r(7'h00, 3'b110, 7, 1, 2));
  emit(enc_r(7'h00, 3'b100, 8, 4, 5));
  run_program("alu_ops", errs_before);
endtask

task automatic test_raw_chain();
  int errs_before;
  errs_before = err_count;
  prog_len = 0;
  emit(enc_addi(10, 0, 1));
  for (int i = 0; i < 4; i++) emit(enc_r(7'h00, 3'b000, 10, 10, 10));
  emit(enc_addi(11, 10, 7));
  emit(enc_r(7'h20, 3'b000, 12, 11, 10));
  emit(enc_r(7'h00, 3'b100, 12, 12, 11));
  run_program("raw_chain", errs_before);
endtask

task automatic test_load_store();
  int errs_before;
  errs_before = err_count;
  prog_len = 0;
  emit(enc_addi(1, 0, 'h100));
  emit(enc_addi(2, 0, 'h77));
  emit(enc_lui(3, 'h12345));
  emit(enc_sw(2, 1, 0));
  emit(enc_sw(3, 1, 4));
  emit(enc_lw(4, 1, 0));
  emit(enc_lw(5, 1, 4));
  emit(enc_lw(6, 1, 'h40));
  emit(enc_r(7'h00, 3'b000, 7, 4, 5));
  emit(enc_sw(7, 1, -4));
  emit(enc_lw(8, 1, -4));
  run_program("load_store", errs_before);
endtask

task automatic test_branches();
  int errs_before;
  errs_before = err_count;
  prog_len = 0;
  emit(enc_addi(1, 0, 3));
  emit(enc_addi(2, 0, 3));
  emit(enc_branch(3'b000, 1, 2, 8));   // Taken, skips the next one
  emit(enc_addi(3, 0, 99));
  emit(enc_addi(4, 0, 1));
  emit(enc_branch(3'b001, 1, 2, 8));   // Not taken
  emit(enc_addi(5, 0, 2));
  emit(enc_branch(3'b001, 1, 4, 12));
  emit(enc_addi(6, 0, 66));
  emit(enc_addi(7, 0, 77));
  emit(enc_branch(3'b000, 1, 4, 8));
  emit(enc_addi(8, 0, 5));
  run_program("branches", errs_before);
endtask

task automatic test_x0_and_nop();
  int errs_before;
  errs_before = err_count;
  prog_len = 0;
  emit(enc_addi(0, 0, 55));
  emit(enc_lui(0, 'hFFFFF));
  emit(enc_r(7'h00, 3'b000, 1, 0, 0));
  emit(32'h0000_100F);                 // FENCE.I
  emit(enc_r(7'h00, 3'b001, 5, 1, 1));  // SLL is outside the subset
  emit(32'hFFFF_FFFF);
  emit(enc_addi(3, 0, 9));
  emit(enc_r(7'h00, 3'b110, 4, 0, 3));
  run_program("x0_and_nop", errs_before);
endtask

`endif

/* tb/tb_backend_core.sv */
// Programs must write every register they read since the register file has no reset, memory addresses stay below 1 KiB
`timescale 1ns/1ps
`default_nettype none

`include "backend_settings.svh"

module tb_backend_core;

  logic        clk_i;
  logic        rst_n_i;
  logic        ibuf_valid_i;
  logic        ibuf_ready_o;
  logic [31:0] ibuf_instr_i;
  logic [31:0] ibuf_pc_i;
  logic        dmem_req_valid_o;
  logic        dmem_req_ready_i;
  logic        dmem_req_we_o;
  logic [31:0] dmem_req_addr_o;
  logic [31:0] dmem_req_wdata_o;
  logic        dmem_rsp_valid_i;
  logic [31:0] dmem_rsp_rdata_i;
  logic        commit_valid_o;
  logic        commit_we_o;
  logic [4:0]  commit_areg_o;
  logic [31:0] commit_wdata_o;
  logic        flush_o;
  logic [31:0] flush_pc_o;

  logic [31:0] prog [0:63];
  int          prog_len;
  logic [31:0] fe_pc;
  logic        fe_run;
  logic [31:0] dmem [0:255];
  logic [31:0] gmem [0:255];
  logic [31:0] gregs [0:31];
  logic [15:0] lfsr_q;
  int          req_cnt;
  int          rsp_cnt;
  logic        rsp_busy;
  logic [31:0] rsp_data;
  logic        exp_we [$];
  logic [4:0]  exp_areg [$];
  logic [31:0] exp_data [$];
  logic [31:0] exp_flush [$];
  logic        mon_we;
  logic [4:0]  mon_areg;
  logic [31:0] mon_data;
  int          err_count;
  int          check_count;
  int          test_count;
  int          instr_total;
  int          cycle_count;

  backend_core backend_core_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Helpers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  function automatic int rand_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      v = (v << 1) | lfsr_q[0];  // One LFSR step per bit
      lfsr_q = lfsr_next(lfsr_q);
    end
    return v;
  endfunction

  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return addr ^ {addr[15:0], 16'h0} ^ 32'hA5C3_0000;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_count++;
    if (actual !== expected) begin
      $display("Error %s expected %h got %h", name, expected, actual);
      err_count++;
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Frontend, memory and commit models
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always @(negedge clk_i) begin
    ibuf_valid_i = fe_run && ((fe_pc >> 2) < prog_len);
    ibuf_instr_i = prog[fe_pc[7:2]];
    ibuf_pc_i    = fe_pc;
  end

  always @(posedge clk_i) begin
    if (flush_o) begin
      fe_pc <= flush_pc_o;  // Offer in the flush cycle is dropped
    end else if (ibuf_valid_i && ibuf_ready_o) begin
      fe_pc <= fe_pc + 32'd4;
    end
  end

  always @(negedge clk_i) begin
    dmem_req_ready_i = 1'b0;
    dmem_rsp_valid_i = 1'b0;
    if (rsp_busy) begin
      if (rsp_cnt == 0) begin
        dmem_rsp_valid_i = 1'b1;
        dmem_rsp_rdata_i = rsp_data;
        rsp_busy         = 1'b0;
        req_cnt          = rand_bits(2);
      end else begin
        rsp_cnt--;
      end
    end else if (dmem_req_valid_o) begin
      if (req_cnt == 0) begin
        dmem_req_ready_i = 1'b1;
        if (dmem_req_we_o) dmem[dmem_req_addr_o[9:2]] = dmem_req_wdata_o;
        rsp_data = dmem[dmem_req_addr_o[9:2]];
        rsp_busy = 1'b1;
        rsp_cnt  = rand_bits(2);
      end else begin
        req_cnt--;
      end
    end
  end

  always @(posedge clk_i) begin
    if (rst_n_i && commit_valid_o) begin
      if (exp_we.size() == 0) begin
        $display("A commit appeared with no instruction left to retire");
        err_count++;
      end else begin
        mon_we   = exp_we.pop_front();
        mon_areg = exp_areg.pop_front();
        mon_data = exp_data.pop_front();
        check_value("commit_we_o", mon_we, commit_we_o);
        if (mon_we) begin
          check_value("commit_areg_o", mon_areg, commit_areg_o);
          check_value("commit_wdata_o", mon_data, commit_wdata_o);
        end
      end
    end
    if (rst_n_i && flush_o) begin
      if (exp_flush.size() == 0) begin
        $display("A flush appeared where no taken branch was expected");
        err_count++;
      end else begin
        check_value("flush_pc_o", exp_flush.pop_front(), flush_pc_o);
      end
    end
  end

  always @(posedge clk_i) begin
    cycle_count++;
    if (cycle_count > instr_total * 12 + 100) begin
      $display("Timeout after %0d cycles with commits still outstanding", cycle_count);
      $display("Test failures found");
      $finish;
    end
  end

  `include "backend_tests.svh"

  initial begin
    rst_n_i          = 1'b0;
    ibuf_valid_i     = 1'b0;
    ibuf_instr_i     = '0;
    ibuf_pc_i        = '0;
    dmem_req_ready_i = 1'b0;
    dmem_rsp_valid_i = 1'b0;
    dmem_rsp_rdata_i = '0;
    fe_pc            = `BACKEND_RESET_PC;
    fe_run           = 1'b0;
    prog_len         = 0;
    lfsr_q           = 16'd31;
    rsp_busy         = 1'b0;
    rsp_cnt          = 0;
    req_cnt          = rand_bits(2);
    for (int i = 0; i < 256; i++) begin
      dmem[i] = fill_word(i << 2);
      gmem[i] = fill_word(i << 2);
    end
    for (int i = 0; i < 32; i++) gregs[i] = '0;
    repeat (4) @(negedge clk_i);
    rst_n_i = 1'b1;
    @(negedge clk_i);
    test_alu_ops();
    test_raw_chain();
    test_load_store();
    test_branches();
    test_x0_and_nop();
    $display("%0d tests, %0d checks, %0d errors", test_count, check_count, err_count);
    if (err_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire
